// File: tb.f
logic/ooo_pkg.sv
logic/ooo_ifs.sv
logic/reorder_buffer.sv
logic/dispatch_unit.sv
logic/int_alu.sv
logic/mul_pipe.sv
logic/div_iter.sv
logic/ooo_core.sv
bench/ooo_checker.sv
bench/ooo_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := ooo_tb
FILELIST  := tb.f
BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/ooo_tb.sv
`timescale 1ns/1ps

module ooo_tb;

    localparam int OP_ADD  = 0;                               // Model op classes
    localparam int OP_SUB  = 1;
    localparam int OP_AND  = 2;
    localparam int OP_XOR  = 3;
    localparam int OP_ADDI = 4;
    localparam int OP_MUL  = 5;
    localparam int OP_DIVU = 6;
    localparam int OP_REMU = 7;
    localparam int N_ALU   = 200;                             // Instructions per test
    localparam int N_MUL   = 48;
    localparam int N_DIV   = 24;
    localparam int N_OOO   = 36;                              // Four rounds of nine
    localparam int N_DEP   = 120;
    localparam int N_FILL  = 63;                              // Three rounds of 21
    localparam int CYCLE_LIMIT = (N_ALU + N_MUL + N_DIV + N_OOO + N_DEP + N_FILL) *
                                 (ooo_pkg::DIV_CYCLES + 8);

    logic        clk = 1'b0;
    logic        rst;
    logic        inst_valid;
    logic [31:0] inst_word;
    logic        inst_ready;
    logic        commit_valid;
    logic [4:0]  commit_dest;
    logic [31:0] commit_value;
    logic [31:0] lcg_state;
    logic [31:0] model_regs [32];                             // In-order architectural copy
    logic        always_valid;                                // No random gaps
    logic        saw_full;
    string       cur_test;
    int          cycles = 0;
    int          tb_errors;
    int          n_accepted;
    int          test_count;
    int          total_accepted;
    int          err_base;
    int          commit_base;

    ooo_core u_dut (
        .clk, .rst, .inst_valid, .inst_word, .inst_ready,
        .commit_valid, .commit_dest, .commit_value
    );

    ooo_checker u_chk (.clk, .rst, .commit_valid, .commit_dest, .commit_value);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: commits stopped arriving");
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Upper bits only, the low ones cycle quickly
    task automatic pick(input int lo, input int hi, output int v);
        lcg_state = lcg_next(lcg_state);
        v = lo + int'(lcg_state[31:8] % 24'(hi - lo + 1));
    endtask

    function automatic logic [31:0] encode(input int op, input int rd, input int rs1,
                                           input int rs2, input int imm);
        case (op)
            OP_SUB:  return {ooo_pkg::F7_SUB, 5'(rs2), 5'(rs1), ooo_pkg::F3_ADD, 5'(rd),
                             ooo_pkg::OPC_OP};
            OP_AND:  return {ooo_pkg::F7_BASE, 5'(rs2), 5'(rs1), ooo_pkg::F3_AND, 5'(rd),
                             ooo_pkg::OPC_OP};
            OP_XOR:  return {ooo_pkg::F7_BASE, 5'(rs2), 5'(rs1), ooo_pkg::F3_XOR, 5'(rd),
                             ooo_pkg::OPC_OP};
            OP_ADDI: return {12'(imm), 5'(rs1), ooo_pkg::F3_ADD, 5'(rd), ooo_pkg::OPC_OP_IMM};
            OP_MUL:  return {ooo_pkg::F7_MULDIV, 5'(rs2), 5'(rs1), ooo_pkg::F3_MUL, 5'(rd),
                             ooo_pkg::OPC_OP};
            OP_DIVU: return {ooo_pkg::F7_MULDIV, 5'(rs2), 5'(rs1), ooo_pkg::F3_DIVU, 5'(rd),
                             ooo_pkg::OPC_OP};
            OP_REMU: return {ooo_pkg::F7_MULDIV, 5'(rs2), 5'(rs1), ooo_pkg::F3_REMU, 5'(rd),
                             ooo_pkg::OPC_OP};
            default: return {ooo_pkg::F7_BASE, 5'(rs2), 5'(rs1), ooo_pkg::F3_ADD, 5'(rd),
                             ooo_pkg::OPC_OP};
        endcase
    endfunction

    function automatic logic [31:0] model_result(input int op, input logic [31:0] a,
                                                 input logic [31:0] b, input logic [11:0] imm);
        case (op)
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_XOR:  return a ^ b;
            OP_ADDI: return a + {{20{imm[11]}}, imm};         // Sign-extended immediate
            OP_MUL:  return a * b;                            // Low word of the product
            OP_DIVU: return (b == 32'd0) ? 32'hffff_ffff : a / b;
            OP_REMU: return (b == 32'd0) ? a : a % b;
            default: return a + b;
        endcase
    endfunction

    task automatic issue(input int op, input int rd, input int rs1, input int rs2, input int imm);
        logic [31:0] word;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        taken;
        int          gap;
        word  = encode(op, rd, rs1, rs2, imm);
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            pick(0, 3, gap);
            inst_valid = always_valid || gap != 0;            // About 3 in 4 cycles
            inst_word  = word;
            #1;                                               // Let inst_ready settle
            if (inst_ready && u_chk.pending_count() >= ooo_pkg::ROB_DEPTH) begin
                $display("%s: inst_ready high with every ROB entry in flight", cur_test);
                tb_errors++;
            end
            if (!inst_ready && u_chk.pending_count() == ooo_pkg::ROB_DEPTH) begin
                saw_full = 1'b1;
            end
            taken = inst_valid && inst_ready;
        end
        a   = (rs1 == 0) ? '0 : model_regs[5'(rs1)];
        b   = (rs2 == 0) ? '0 : model_regs[5'(rs2)];
        res = model_result(op, a, b, 12'(imm));
        if (rd == 0) begin
            res = '0;                                         // x0 discards the result
        end else begin
            model_regs[5'(rd)] = res;
        end
        u_chk.expect_result(rd, res);
        n_accepted++;
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        n_accepted  = 0;
        saw_full    = 1'b0;
        err_base    = u_chk.err_count + tb_errors;
        commit_base = u_chk.commit_count;
        u_chk.set_test(name);
    endtask

    task automatic end_test();
        int commits;
        int errs;
        @(negedge clk);
        inst_valid   = 1'b0;
        always_valid = 1'b0;
        while (u_chk.pending_count() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);                            // Room for a stray commit
        #1;
        commits = u_chk.commit_count - commit_base;
        if (commits != n_accepted) begin
            $display("Error: %s commit count expected %0d actual %0d",
                     cur_test, n_accepted, commits);
            tb_errors++;
        end
        errs = u_chk.err_count + tb_errors - err_base;
        $display("%s: accepted %0d, committed %0d, errors %0d",
                 cur_test, n_accepted, commits, errs);
        test_count++;
        total_accepted += n_accepted;
    endtask

    initial begin
        int op;
        int rd;
        int rs1;
        int rs2;
        int imm;
        int total_errors;
        rst            = 1'b1;
        inst_valid     = 1'b0;
        inst_word      = '0;
        lcg_state      = 32'h6d7df74a;
        always_valid   = 1'b0;
        saw_full       = 1'b0;
        tb_errors      = 0;
        test_count     = 0;
        total_accepted = 0;
        model_regs     = '{default: '0};
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        begin_test("alu_only");
        for (int n = 0; n < N_ALU; n++) begin
            pick(OP_ADD, OP_ADDI, op);
            pick(0, 31, rd);                                  // x0 included
            pick(0, 31, rs1);
            pick(0, 31, rs2);
            pick(0, 4095, imm);
            issue(op, rd, rs1, rs2, imm);
        end
        end_test();

        begin_test("mul_stream");
        always_valid = 1'b1;
        for (int n = 0; n < N_MUL; n++) begin
            pick(1, 15, rs1);                                 // Sources never written here
            pick(1, 15, rs2);
            issue(OP_MUL, 16 + n % 16, rs1, rs2, 0);
        end
        end_test();

        begin_test("div_mixed");
        for (int n = 0; n < N_DIV; n++) begin
            pick(OP_DIVU, OP_REMU, op);
            pick(1, 31, rd);
            pick(1, 31, rs1);
            pick(1, 31, rs2);
            if (n % 4 == 3) begin
                rs2 = 0;                                      // Divide by zero
            end
            issue(op, rd, rs1, rs2, 0);
        end
        end_test();

        begin_test("out_of_order");
        always_valid = 1'b1;
        for (int n = 0; n < N_OOO / 9; n++) begin
            issue(OP_DIVU, 20, 1, 2, 0);                      // Slow head entry
            for (int k = 0; k < 8; k++) begin
                pick(OP_ADD, OP_ADDI, op);
                pick(3, 9, rs1);
                pick(3, 9, rs2);
                pick(0, 4095, imm);
                issue(op, 21 + k, rs1, rs2, imm);
            end
        end
        end_test();

        begin_test("dependency_chains");
        for (int n = 0; n < N_DEP; n++) begin
            pick(OP_ADD, OP_REMU, op);                        // Every unit
            pick(1, 4, rd);
            pick(1, 4, rs1);
            pick(1, 4, rs2);
            pick(0, 4095, imm);
            issue(op, rd, rs1, rs2, imm);
        end
        end_test();

        begin_test("rob_fill");
        always_valid = 1'b1;
        for (int n = 0; n < N_FILL / 21; n++) begin
            issue(OP_DIVU, 30, 5, 6, 0);                      // Blocks commit for a while
            for (int k = 0; k < 20; k++) begin
                pick(OP_ADD, OP_ADDI, op);
                pick(1, 9, rs1);
                pick(1, 9, rs2);
                pick(0, 4095, imm);
                issue(op, 10 + k, rs1, rs2, imm);
            end
        end
        if (!saw_full) begin
            $display("rob_fill: inst_ready never fell with all ROB entries in flight");
            tb_errors++;
        end
        end_test();

        total_errors = u_chk.err_count + tb_errors;
        $display("%0d tests, %0d accepted, %0d committed, %0d errors",
                 test_count, total_accepted, u_chk.commit_count, total_errors);
        if (total_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: bench/ooo_checker.sv
`timescale 1ns/1ps

module ooo_checker (
    input logic        clk,
    input logic        rst,
    input logic        commit_valid,
    input logic [4:0]  commit_dest,
    input logic [31:0] commit_value
);

    logic [36:0] exp_q [$];                                   // {dest, value} in program order
    string       test_name = "reset";
    int          err_count = 0;
    int          commit_count = 0;

    // Called by the model once per accepted instruction
    function automatic void expect_result(input int dest, input logic [31:0] value);
        exp_q.push_back({5'(dest), value});
    endfunction

    function automatic int pending_count();
        return exp_q.size();                                  // Accepted but not yet committed
    endfunction

    function automatic void set_test(input string name);
        test_name = name;
    endfunction

    // Commit pulses span a full cycle, low phase is the quiet point
    always @(negedge clk) begin
        logic [36:0] exp;
        if (!rst && commit_valid) begin
            commit_count = commit_count + 1;
            if (exp_q.size() == 0) begin
                $display("%s: commit to x%0d arrived with no instruction outstanding",
                         test_name, commit_dest);
                err_count = err_count + 1;
            end else begin
                exp = exp_q.pop_front();                      // Oldest expected result
                if (exp[36:32] !== commit_dest || exp[31:0] !== commit_value) begin
                    $display("Error: %s expected x%0d=%08h actual x%0d=%08h",
                             test_name, exp[36:32], exp[31:0], commit_dest, commit_value);
                    err_count = err_count + 1;
                end
            end
        end
    end

endmodule

// File: logic/ooo_core.sv
`timescale 1ns/1ps

module ooo_core (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     inst_valid,
    input  logic [31:0]              inst_word,
    output logic                     inst_ready,
    output logic                     commit_valid,
    output logic [4:0]               commit_dest,
    output logic [ooo_pkg::XLEN-1:0] commit_value
);

    alloc_if alloc ();
    wb_if    wb_alu ();
    wb_if    wb_mul ();
    wb_if    wb_div ();

    logic                      alu_start;
    ooo_pkg::alu_op_e          alu_op;
    logic [ooo_pkg::XLEN-1:0]  alu_a;
    logic [ooo_pkg::XLEN-1:0]  alu_b;
    logic [ooo_pkg::TAG_W-1:0] alu_tag;
    logic                      mul_start;
    logic [ooo_pkg::XLEN-1:0]  mul_a;
    logic [ooo_pkg::XLEN-1:0]  mul_b;
    logic [ooo_pkg::TAG_W-1:0] mul_tag;
    logic                      div_start;
    logic                      div_rem;
    logic [ooo_pkg::XLEN-1:0]  div_a;
    logic [ooo_pkg::XLEN-1:0]  div_b;
    logic [ooo_pkg::TAG_W-1:0] div_tag;
    logic                      div_busy;
    logic [ooo_pkg::TAG_W-1:0] commit_tag;                    // Internal only

    dispatch_unit u_dispatch (
        .clk, .rst, .inst_valid, .inst_word, .inst_ready, .alloc,
        .alu_start, .alu_op, .alu_a, .alu_b, .alu_tag,
        .mul_start, .mul_a, .mul_b, .mul_tag,
        .div_start, .div_rem, .div_a, .div_b, .div_tag, .div_busy,
        .commit_valid, .commit_tag, .commit_dest, .commit_value
    );

    reorder_buffer u_rob (
        .clk, .rst, .alloc, .wb_alu, .wb_mul, .wb_div,
        .commit_valid, .commit_tag, .commit_dest, .commit_value
    );

    int_alu u_alu (
        .clk, .rst, .start(alu_start), .op(alu_op), .a(alu_a), .b(alu_b),
        .tag(alu_tag), .wb(wb_alu)
    );

    mul_pipe u_mul (
        .clk, .rst, .start(mul_start), .a(mul_a), .b(mul_b), .tag(mul_tag), .wb(wb_mul)
    );

    div_iter u_div (
        .clk, .rst, .start(div_start), .rem_sel(div_rem), .a(div_a), .b(div_b),
        .tag(div_tag), .busy(div_busy), .wb(wb_div)
    );

endmodule

// File: logic/div_iter.sv
`timescale 1ns/1ps

module div_iter (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  logic                      rem_sel,
    input  logic [ooo_pkg::XLEN-1:0]  a,
    input  logic [ooo_pkg::XLEN-1:0]  b,
    input  logic [ooo_pkg::TAG_W-1:0] tag,
    output logic                      busy,
    wb_if.unit                        wb
);

    logic [ooo_pkg::DIV_CNT_W-1:0] cnt;                       // Steps left
    logic [ooo_pkg::XLEN-1:0]      quo;                       // Dividend in, quotient out
    logic [ooo_pkg::XLEN-1:0]      rmd;                       // Partial remainder
    logic [ooo_pkg::XLEN-1:0]      dvs;
    logic                          rem_q;
    logic [ooo_pkg::TAG_W-1:0]     tag_q;
    logic [ooo_pkg::XLEN:0]        shifted;
    logic [ooo_pkg::XLEN:0]        trial;
    logic [ooo_pkg::XLEN-1:0]      quo_next;
    logic [ooo_pkg::XLEN-1:0]      rmd_next;
    logic                          last;

    // Zero divisor always subtracts, giving all-ones quotient and dividend remainder
    always_comb begin
        shifted = {rmd, quo[ooo_pkg::XLEN-1]};
        trial   = shifted - {1'b0, dvs};
        if (!trial[ooo_pkg::XLEN]) begin
            rmd_next = trial[ooo_pkg::XLEN-1:0];              // Fits, keep difference
            quo_next = {quo[ooo_pkg::XLEN-2:0], 1'b1};
        end else begin
            rmd_next = shifted[ooo_pkg::XLEN-1:0];            // Restore
            quo_next = {quo[ooo_pkg::XLEN-2:0], 1'b0};
        end
    end

    assign last = busy && cnt == ooo_pkg::DIV_CNT_W'(1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy    <= 1'b0;
            cnt     <= '0;
            wb.done <= 1'b0;
        end else begin
            wb.done <= last;                                  // Pulse with the final step
            if (start) begin
                busy <= 1'b1;
                cnt  <= ooo_pkg::DIV_CNT_W'(ooo_pkg::DIV_CYCLES);
            end else if (busy) begin
                cnt <= cnt - 1'b1;
                if (last) begin
                    busy <= 1'b0;                             // Free for the next edge
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            quo   <= a;
            dvs   <= b;
            rmd   <= '0;
            rem_q <= rem_sel;
            tag_q <= tag;
        end else if (busy) begin
            quo <= quo_next;
            rmd <= rmd_next;
        end
        if (last) begin
            wb.value <= rem_q ? rmd_next : quo_next;
        end
    end

    assign wb.tag = tag_q;

endmodule

// File: logic/mul_pipe.sv
`timescale 1ns/1ps

module mul_pipe (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  logic [ooo_pkg::XLEN-1:0]  a,
    input  logic [ooo_pkg::XLEN-1:0]  b,
    input  logic [ooo_pkg::TAG_W-1:0] tag,
    wb_if.unit                        wb
);

    logic [ooo_pkg::MUL_STAGES-1:0] vld;                      // One bit per stage
    logic [ooo_pkg::TAG_W-1:0]      tag_q [ooo_pkg::MUL_STAGES];
    logic [ooo_pkg::XLEN-1:0]       a_q;
    logic [ooo_pkg::XLEN-1:0]       b_q;
    logic [ooo_pkg::XLEN-1:0]       lo_q;                     // a_lo * b, low word
    logic [15:0]                    hi_q;                     // a_hi * b_lo, only low half counts
    logic [ooo_pkg::XLEN-1:0]       prod_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vld <= '0;
        end else begin
            vld <= {vld[ooo_pkg::MUL_STAGES-2:0], start};
        end
    end

    always_ff @(posedge clk) begin
        tag_q[0] <= tag;
        for (int s = 1; s < ooo_pkg::MUL_STAGES; s++) begin
            tag_q[s] <= tag_q[s-1];
        end
        a_q    <= a;                                          // Stage 1 operands
        b_q    <= b;
        lo_q   <= {16'b0, a_q[15:0]} * b_q;                   // Stage 2 partial products
        hi_q   <= a_q[31:16] * b_q[15:0];
        prod_q <= lo_q + {hi_q, 16'b0};                       // Stage 3 sum, mod 2^32
    end

    assign wb.done  = vld[ooo_pkg::MUL_STAGES-1];
    assign wb.tag   = tag_q[ooo_pkg::MUL_STAGES-1];
    assign wb.value = prod_q;

endmodule

// File: logic/int_alu.sv
`timescale 1ns/1ps

module int_alu (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  ooo_pkg::alu_op_e          op,
    input  logic [ooo_pkg::XLEN-1:0]  a,
    input  logic [ooo_pkg::XLEN-1:0]  b,
    input  logic [ooo_pkg::TAG_W-1:0] tag,
    wb_if.unit                        wb
);

    logic [ooo_pkg::XLEN-1:0] result;

    always_comb begin
        case (op)
            ooo_pkg::ALU_SUB: result = a - b;
            ooo_pkg::ALU_AND: result = a & b;
            ooo_pkg::ALU_XOR: result = a ^ b;
            default:          result = a + b;                 // add and addi
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb.done <= 1'b0;
        end else begin
            wb.done <= start;                                 // Fixed single cycle
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            wb.tag   <= tag;
            wb.value <= result;
        end
    end

endmodule

// File: logic/dispatch_unit.sv
`timescale 1ns/1ps

module dispatch_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      inst_valid,
    input  logic [31:0]               inst_word,
    output logic                      inst_ready,
    alloc_if.disp                     alloc,
    output logic                      alu_start,
    output ooo_pkg::alu_op_e          alu_op,
    output logic [ooo_pkg::XLEN-1:0]  alu_a,
    output logic [ooo_pkg::XLEN-1:0]  alu_b,
    output logic [ooo_pkg::TAG_W-1:0] alu_tag,
    output logic                      mul_start,
    output logic [ooo_pkg::XLEN-1:0]  mul_a,
    output logic [ooo_pkg::XLEN-1:0]  mul_b,
    output logic [ooo_pkg::TAG_W-1:0] mul_tag,
    output logic                      div_start,
    output logic                      div_rem,
    output logic [ooo_pkg::XLEN-1:0]  div_a,
    output logic [ooo_pkg::XLEN-1:0]  div_b,
    output logic [ooo_pkg::TAG_W-1:0] div_tag,
    input  logic                      div_busy,
    input  logic                      commit_valid,
    input  logic [ooo_pkg::TAG_W-1:0] commit_tag,
    input  logic [4:0]                commit_dest,
    input  logic [ooo_pkg::XLEN-1:0]  commit_value
);

    ooo_pkg::inst_u            inst;
    ooo_pkg::unit_e            unit;
    logic                      is_op;
    logic                      is_imm;
    logic                      accept;
    logic                      rs1_busy;
    logic                      rs2_busy;
    logic [ooo_pkg::XLEN-1:0]  regs  [ooo_pkg::NUM_REGS];    // Architectural state
    logic [ooo_pkg::NUM_REGS-1:0] busy;                       // Waiting for a commit
    logic [ooo_pkg::TAG_W-1:0] owner [ooo_pkg::NUM_REGS];    // Youngest writer's entry
    logic [ooo_pkg::XLEN-1:0]  src_a;
    logic [ooo_pkg::XLEN-1:0]  src_b;

    assign inst   = inst_word;
    assign is_op  = inst.r.opcode == ooo_pkg::OPC_OP;
    assign is_imm = inst.i.opcode == ooo_pkg::OPC_OP_IMM;

    always_comb begin
        unit = ooo_pkg::UNIT_ALU;
        if (is_op && inst.r.funct7 == ooo_pkg::F7_MULDIV) begin
            if (inst.r.funct3 == ooo_pkg::F3_MUL) begin
                unit = ooo_pkg::UNIT_MUL;
            end else if (inst.r.funct3 == ooo_pkg::F3_DIVU ||
                         inst.r.funct3 == ooo_pkg::F3_REMU) begin
                unit = ooo_pkg::UNIT_DIV;
            end
        end
    end

    always_comb begin
        alu_op = ooo_pkg::ALU_ADD;                            // addi and add
        if (is_op && inst.r.funct7 == ooo_pkg::F7_SUB && inst.r.funct3 == ooo_pkg::F3_ADD) begin
            alu_op = ooo_pkg::ALU_SUB;
        end else if (is_op && inst.r.funct7 == ooo_pkg::F7_BASE) begin
            if (inst.r.funct3 == ooo_pkg::F3_XOR) begin
                alu_op = ooo_pkg::ALU_XOR;
            end else if (inst.r.funct3 == ooo_pkg::F3_AND) begin
                alu_op = ooo_pkg::ALU_AND;
            end
        end
    end

    assign rs1_busy   = busy[inst.r.rs1];
    assign rs2_busy   = is_op && busy[inst.r.rs2];            // addi has no rs2
    assign inst_ready = !alloc.full && !rs1_busy && !rs2_busy &&
                        !(unit == ooo_pkg::UNIT_DIV && div_busy);
    assign accept     = inst_valid && inst_ready;

    assign alloc.valid = accept;
    assign alloc.dest  = inst.r.rd;

    assign src_a = (inst.r.rs1 == 5'd0) ? '0 : regs[inst.r.rs1];
    assign src_b = is_imm ? {{(ooo_pkg::XLEN - 12){inst.i.imm[11]}}, inst.i.imm}
                 : (inst.r.rs2 == 5'd0) ? '0 : regs[inst.r.rs2];

    assign alu_start = accept && unit == ooo_pkg::UNIT_ALU;
    assign mul_start = accept && unit == ooo_pkg::UNIT_MUL;
    assign div_start = accept && unit == ooo_pkg::UNIT_DIV;
    assign div_rem   = inst.r.funct3 == ooo_pkg::F3_REMU;
    assign alu_a     = src_a;
    assign alu_b     = src_b;
    assign mul_a     = src_a;
    assign mul_b     = src_b;
    assign div_a     = src_a;
    assign div_b     = src_b;
    assign alu_tag   = alloc.tag;
    assign mul_tag   = alloc.tag;
    assign div_tag   = alloc.tag;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= '0;
            for (int i = 0; i < ooo_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (commit_valid && commit_dest != 5'd0) begin
                regs[commit_dest] <= commit_value;
                if (owner[commit_dest] == commit_tag) begin
                    busy[commit_dest] <= 1'b0;                // Only the newest writer frees it
                end
            end
            if (accept && inst.r.rd != 5'd0) begin
                busy[inst.r.rd] <= 1'b1;                      // Overrides a same-edge clear
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && inst.r.rd != 5'd0) begin
            owner[inst.r.rd] <= alloc.tag;
        end
    end

    a_legal_opcode: assert property (@(posedge clk) disable iff (rst)
        accept |-> is_op || is_imm);

endmodule

// File: logic/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer (
    input  logic                      clk,
    input  logic                      rst,
    alloc_if.rob                      alloc,
    wb_if.rob                         wb_alu,
    wb_if.rob                         wb_mul,
    wb_if.rob                         wb_div,
    output logic                      commit_valid,
    output logic [ooo_pkg::TAG_W-1:0] commit_tag,
    output logic [4:0]                commit_dest,
    output logic [ooo_pkg::XLEN-1:0]  commit_value
);

    logic [ooo_pkg::ROB_DEPTH-1:0] ent_valid;                 // Entry holds an instruction
    logic [ooo_pkg::ROB_DEPTH-1:0] ent_ready;                 // Result has arrived
    logic [4:0]                    ent_dest  [ooo_pkg::ROB_DEPTH];
    logic [ooo_pkg::XLEN-1:0]      ent_value [ooo_pkg::ROB_DEPTH];
    logic [ooo_pkg::TAG_W-1:0]     head;                      // Oldest entry
    logic [ooo_pkg::TAG_W-1:0]     tail;                      // Next free entry
    logic [ooo_pkg::TAG_W:0]       count;                     // Occupancy, one bit wider
    logic                          do_alloc;
    logic                          do_commit;

    assign do_alloc   = alloc.valid && !alloc.full;
    assign do_commit  = ent_valid[head] && ent_ready[head];  // Strictly in order
    assign alloc.full = count == (ooo_pkg::TAG_W + 1)'(ooo_pkg::ROB_DEPTH);
    assign alloc.tag  = tail;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ent_valid    <= '0;
            ent_ready    <= '0;
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            commit_valid <= 1'b0;
        end else begin
            if (do_alloc) begin
                ent_valid[tail] <= 1'b1;
                ent_ready[tail] <= 1'b0;
                tail            <= tail + 1'b1;               // Depth is a power of two
            end
            if (wb_alu.done) begin
                ent_ready[wb_alu.tag] <= 1'b1;
            end
            if (wb_mul.done) begin
                ent_ready[wb_mul.tag] <= 1'b1;
            end
            if (wb_div.done) begin
                ent_ready[wb_div.tag] <= 1'b1;
            end
            if (do_commit) begin
                ent_valid[head] <= 1'b0;
                head            <= head + 1'b1;
            end
            commit_valid <= do_commit;                        // Single pulse per entry
            case ({do_alloc, do_commit})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;                      // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_alloc) begin
            ent_dest[tail] <= alloc.dest;
        end
        if (wb_alu.done) begin
            ent_value[wb_alu.tag] <= wb_alu.value;
        end
        if (wb_mul.done) begin
            ent_value[wb_mul.tag] <= wb_mul.value;
        end
        if (wb_div.done) begin
            ent_value[wb_div.tag] <= wb_div.value;
        end
        if (do_commit) begin
            commit_tag   <= head;
            commit_dest  <= ent_dest[head];
            // x0 discards its result, so it leaves as zero
            commit_value <= (ent_dest[head] == 5'd0) ? '0 : ent_value[head];
        end
    end

    // Units only answer for live entries, and each entry once
    a_wb_alu_live: assert property (@(posedge clk) disable iff (rst)
        wb_alu.done |-> ent_valid[wb_alu.tag] && !ent_ready[wb_alu.tag]);
    a_wb_mul_live: assert property (@(posedge clk) disable iff (rst)
        wb_mul.done |-> ent_valid[wb_mul.tag] && !ent_ready[wb_mul.tag]);
    a_wb_div_live: assert property (@(posedge clk) disable iff (rst)
        wb_div.done |-> ent_valid[wb_div.tag] && !ent_ready[wb_div.tag]);

endmodule

// File: logic/ooo_ifs.sv
`timescale 1ns/1ps

interface alloc_if;
    logic                      valid;  // Dispatch claims an entry
    logic [4:0]                dest;   // Destination register of the claim
    logic                      full;   // No free entry
    logic [ooo_pkg::TAG_W-1:0] tag;    // Current tail, the entry handed out

    modport disp (
        output valid,
        output dest,
        input  full,
        input  tag
    );

    modport rob (
        input  valid,
        input  dest,
        output full,
        output tag
    );
endinterface

interface wb_if;
    logic                      done;   // One-cycle result pulse
    logic [ooo_pkg::TAG_W-1:0] tag;    // Entry the result belongs to
    logic [ooo_pkg::XLEN-1:0]  value;

    modport unit (
        output done,
        output tag,
        output value
    );

    modport rob (
        input done,
        input tag,
        input value
    );
endinterface

// File: logic/ooo_pkg.sv
package ooo_pkg;

    localparam int XLEN       = 32;             // Data path width
    localparam int NUM_REGS   = 32;             // Architectural registers
    localparam int ROB_DEPTH  = 16;             // Reorder buffer entries
    localparam int TAG_W      = 4;              // Entry index width
    localparam int MUL_STAGES = 3;              // Multiplier pipeline depth
    localparam int DIV_CYCLES = 32;             // One quotient bit per step
    localparam int DIV_CNT_W  = 6;              // Holds DIV_CYCLES

    localparam logic [6:0] OPC_OP     = 7'h33;  // Register-register
    localparam logic [6:0] OPC_OP_IMM = 7'h13;  // Register-immediate

    localparam logic [6:0] F7_BASE   = 7'h00;
    localparam logic [6:0] F7_SUB    = 7'h20;
    localparam logic [6:0] F7_MULDIV = 7'h01;   // M extension group

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_MUL  = 3'b000;
    localparam logic [2:0] F3_DIVU = 3'b101;
    localparam logic [2:0] F3_REMU = 3'b111;

    typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_XOR} alu_op_e;

    typedef enum logic [1:0] {UNIT_ALU, UNIT_MUL, UNIT_DIV} unit_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;                       // Overlays funct7 and rs2
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } inst_u;

endpackage
